// File: logic/mul_pkg.sv
`default_nettype none

package mul_pkg;

    localparam int op_width = 16;
    localparam int prod_width = 2 * op_width;

    // one partial product per multiplier bit
    localparam int n_pp_rows = op_width;

    // bits per lookahead group in the final adder
    localparam int cla_group = 4;

    // rows entering each csa level
    // last entry is what reaches the adder
    localparam int layer_rows [7] = '{n_pp_rows, 11, 8, 6, 4, 3, 2};

    // levels ahead of the first register
    localparam int pipe_level = 3;

    typedef logic [op_width-1:0] operand_t;
    typedef logic [prod_width-1:0] row_t;

    typedef row_t [n_pp_rows-1:0] pp_rows_t;

    // rows held between the two pipeline stages
    typedef row_t [layer_rows[pipe_level]-1:0] mid_rows_t;

    // 3:2 compression per group of three, leftovers pass through
    function automatic int csa_out_rows(input int n_in);
        int n_groups;
        int n_rem;
        n_groups = n_in / 3;
        n_rem = n_in % 3;
        return 2 * n_groups + n_rem;
    endfunction

endpackage

`default_nettype wire

// File: logic/partial_product_gen.sv
`timescale 1ns/100ps
`default_nettype none

module partial_product_gen (
    input  mul_pkg::operand_t a,
    input  mul_pkg::operand_t b,
    output mul_pkg::pp_rows_t rows
);
    import mul_pkg::*;

    row_t a_ext;

    // zero-extend once, shared by every row
    assign a_ext = row_t'(a);

    for (genvar i = 0; i < n_pp_rows; i++) begin : gen_row
        row_t masked;

        // a gated by multiplier bit i
        assign masked = a_ext & {prod_width{b[i]}};

        // weight 2^i
        assign rows[i] = masked << i;
    end

endmodule

`default_nettype wire

// File: logic/csa_layer.sv
`timescale 1ns/100ps
`default_nettype none

module csa_layer #(
    parameter int n_in = 3
) (
    input  mul_pkg::row_t [n_in-1:0]                         rows_in,
    output mul_pkg::row_t [mul_pkg::csa_out_rows(n_in)-1:0] rows_out
);
    import mul_pkg::*;

    localparam int n_groups = n_in / 3;
    localparam int n_rem = n_in % 3;

    // full adders across each group of three rows
    for (genvar g = 0; g < n_groups; g++) begin : gen_group
        row_t x;
        row_t y;
        row_t z;
        row_t maj;

        assign x = rows_in[3*g];
        assign y = rows_in[3*g+1];
        assign z = rows_in[3*g+2];

        assign maj = (x & y) | (y & z) | (z & x);

        assign rows_out[2*g] = x ^ y ^ z;

        // carries land one column up, top bit falls off
        assign rows_out[2*g+1] = maj << 1;
    end

    // leftover rows go to the next level untouched
    for (genvar r = 0; r < n_rem; r++) begin : gen_pass
        assign rows_out[2*n_groups+r] = rows_in[3*n_groups+r];
    end

endmodule

`default_nettype wire

// File: logic/cla_adder.sv
`timescale 1ns/100ps
`default_nettype none

module cla_adder (
    input  mul_pkg::row_t x,
    input  mul_pkg::row_t y,
    output mul_pkg::row_t sum
);
    import mul_pkg::*;

    localparam int n_groups = prod_width / cla_group;
    localparam int lw = (n_groups > cla_group) ? n_groups : cla_group;

    row_t g;
    row_t p;
    row_t c;

    logic [n_groups-1:0] grp_g;
    logic [n_groups-1:0] grp_p;
    logic [n_groups-1:0] grp_c;

    // carry into position n, flattened sum of products
    function automatic logic look_carry(
        input logic [lw-1:0] gv,
        input logic [lw-1:0] pv,
        input logic          cin,
        input int            n
    );
        logic acc;
        logic term;
        acc = cin;
        for (int m = 0; m < n; m++) begin
            acc = acc & pv[m];
        end
        for (int j = 0; j < n; j++) begin
            term = gv[j];
            for (int m = j + 1; m < n; m++) begin
                term = term & pv[m];
            end
            acc = acc | term;
        end
        return acc;
    endfunction

    assign g = x & y;
    assign p = x ^ y;

    for (genvar k = 0; k < n_groups; k++) begin : gen_grp
        assign grp_g[k] = look_carry(lw'(g[k*cla_group +: cla_group]),
                                     lw'(p[k*cla_group +: cla_group]), 1'b0, cla_group);
        assign grp_p[k] = &p[k*cla_group +: cla_group];
    end

    // second level over the groups, no carry in
    always_comb begin
        for (int k = 0; k < n_groups; k++) begin
            grp_c[k] = look_carry(lw'(grp_g), lw'(grp_p), 1'b0, k);
        end
    end

    // carries inside each group from its group carry
    for (genvar k = 0; k < n_groups; k++) begin : gen_inner
        for (genvar b = 0; b < cla_group; b++) begin : gen_bit
            assign c[k*cla_group+b] = look_carry(lw'(g[k*cla_group +: cla_group]),
                                                 lw'(p[k*cla_group +: cla_group]),
                                                 grp_c[k], b);
        end
    end

    assign sum = p ^ c;

endmodule

`default_nettype wire

// File: logic/pipe_stage.sv
`timescale 1ns/100ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = mul_pkg::row_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     valid_in,
    input  payload_t data_in,
    output logic     valid_out,
    output payload_t data_out
);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    // payload holds between valid items
    always_ff @(posedge clk) begin
        if (valid_in) begin
            data_out <= data_in;
        end
    end

endmodule

`default_nettype wire

// File: logic/mul_top.sv
`timescale 1ns/100ps
`default_nettype none

module mul_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  mul_pkg::operand_t a,
    input  mul_pkg::operand_t b,
    output logic              out_valid,
    output mul_pkg::row_t     product
);
    import mul_pkg::*;

    pp_rows_t                  pp_rows;
    row_t [layer_rows[1]-1:0] l1_rows;
    row_t [layer_rows[2]-1:0] l2_rows;
    mid_rows_t                 l3_rows;

    logic                      mid_valid;
    mid_rows_t                 mid_rows;

    row_t [layer_rows[4]-1:0] l4_rows;
    row_t [layer_rows[5]-1:0] l5_rows;
    row_t [layer_rows[6]-1:0] l6_rows;
    row_t                      sum;

    partial_product_gen pp_gen_i (
        .a    (a),
        .b    (b),
        .rows (pp_rows)
    );

    // 16 -> 11 -> 8 -> 6
    csa_layer #(.n_in(layer_rows[0])) layer_1_i (.rows_in(pp_rows), .rows_out(l1_rows));
    csa_layer #(.n_in(layer_rows[1])) layer_2_i (.rows_in(l1_rows), .rows_out(l2_rows));
    csa_layer #(.n_in(layer_rows[2])) layer_3_i (.rows_in(l2_rows), .rows_out(l3_rows));

    pipe_stage #(.payload_t(mid_rows_t)) mid_stage_i (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (in_valid),
        .data_in   (l3_rows),
        .valid_out (mid_valid),
        .data_out  (mid_rows)
    );

    // 6 -> 4 -> 3 -> 2
    csa_layer #(.n_in(layer_rows[3])) layer_4_i (.rows_in(mid_rows), .rows_out(l4_rows));
    csa_layer #(.n_in(layer_rows[4])) layer_5_i (.rows_in(l4_rows), .rows_out(l5_rows));
    csa_layer #(.n_in(layer_rows[5])) layer_6_i (.rows_in(l5_rows), .rows_out(l6_rows));

    cla_adder cla_i (
        .x   (l6_rows[0]),
        .y   (l6_rows[1]),
        .sum (sum)
    );

    pipe_stage #(.payload_t(row_t)) out_stage_i (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (mid_valid),
        .data_in   (sum),
        .valid_out (out_valid),
        .data_out  (product)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter realtime period = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: testbench/mul_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mul_tb;
    import mul_pkg::*;

    localparam int seed = 2778;
    localparam int reset_cycles = 16;
    localparam int n_burst = 24;
    localparam int n_random = 400;
    localparam int drain_limit = 20;

    logic     clk;
    logic     rst;
    logic     in_valid;
    operand_t a;
    operand_t b;
    logic     out_valid;
    row_t     product;

    int    cycle_count = 0;
    int    n_checks = 0;
    int    value_errors = 0;
    int    other_errors = 0;
    int    n_strobes = 0;
    int    n_results = 0;
    bit    check_en = 1'b0;
    bit    have_last = 1'b0;
    row_t  last_product;
    string phase = "reset";

    // expected results in issue order with their arrival cycle
    row_t  exp_prod_q [$];
    int    exp_cycle_q [$];
    string exp_name_q [$];

    tb_clock clock_i (
        .clk (clk)
    );

    mul_top mul_top_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .product   (product)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic compare_value(input string name, input row_t expected, input row_t actual);
        n_checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("** Error [%s] cycle %0d: expected 0x%08h, actual 0x%08h",
                     name, cycle_count, expected, actual);
        end
    endtask

    // one output check per cycle
    task automatic check_outputs();
        string name;
        row_t  expected;
        if (out_valid === 1'b1) begin
            n_results++;
        end
        if (exp_cycle_q.size() > 0 && exp_cycle_q[0] == cycle_count) begin
            name = exp_name_q.pop_front();
            expected = exp_prod_q.pop_front();
            void'(exp_cycle_q.pop_front());
            compare_value({name, " out_valid"}, row_t'(1'b1), row_t'(out_valid));
            compare_value(name, expected, product);
            last_product = expected;
            have_last = 1'b1;
        end else begin
            compare_value({phase, " idle out_valid"}, row_t'(1'b0), row_t'(out_valid));
            // product only holds once something was loaded
            if (have_last) begin
                compare_value({phase, " hold"}, last_product, product);
            end
        end
    endtask

    always @(negedge clk) begin
        if (check_en) begin
            check_outputs();
        end
    end

    function automatic operand_t rand_operand();
        int unsigned pick;
        pick = $urandom_range(15, 0);
        case (pick)
            0: rand_operand = '0;
            1: rand_operand = operand_t'(1);
            2: rand_operand = '1;
            default: rand_operand = operand_t'($urandom);
        endcase
    endfunction

    // result expected two cycles after the cycle it is presented in
    task automatic drive_inputs(input bit valid, input operand_t x, input operand_t y,
                                input string name);
        @(posedge clk);
        #1;
        in_valid = valid;
        a = x;
        b = y;
        if (valid) begin
            exp_prod_q.push_back(row_t'(x) * row_t'(y));
            exp_cycle_q.push_back(cycle_count + 2);
            exp_name_q.push_back(name);
            n_strobes++;
        end
    endtask

    // operands still toggle while in_valid is low
    task automatic idle_cycles(input int n);
        operand_t x;
        operand_t y;
        for (int i = 0; i < n; i++) begin
            x = rand_operand();
            y = rand_operand();
            drive_inputs(1'b0, x, y, phase);
        end
    endtask

    task automatic corner_operands();
        operand_t x;
        operand_t y;
        drive_inputs(1'b1, 16'h0000, 16'h0000, "corner_zero");
        drive_inputs(1'b1, 16'h0000, 16'hFFFF, "corner_zero");
        drive_inputs(1'b1, 16'hFFFF, 16'h0000, "corner_zero");
        drive_inputs(1'b1, 16'h0001, 16'h0001, "corner_one");
        drive_inputs(1'b1, 16'h0001, 16'hFFFF, "corner_one");
        drive_inputs(1'b1, 16'hFFFF, 16'h0001, "corner_one");
        drive_inputs(1'b1, 16'hFFFF, 16'hFFFF, "corner_max");
        for (int i = 0; i < op_width; i++) begin
            x = operand_t'(1) << i;
            y = operand_t'(1) << (op_width - 1 - i);
            drive_inputs(1'b1, x, y, "single_bit");
        end
        for (int i = 0; i < op_width; i++) begin
            x = operand_t'(1) << i;
            drive_inputs(1'b1, x, 16'hFFFF, "single_bit_max");
            drive_inputs(1'b1, 16'hFFFF, x, "single_bit_max");
        end
    endtask

    // strobe on every cycle to keep two items in flight
    task automatic burst_strobes();
        operand_t x;
        operand_t y;
        for (int i = 0; i < n_burst; i++) begin
            x = rand_operand();
            y = rand_operand();
            drive_inputs(1'b1, x, y, "back_to_back");
        end
    endtask

    task automatic random_traffic();
        bit       valid;
        operand_t x;
        operand_t y;
        for (int i = 0; i < n_random; i++) begin
            valid = ($urandom_range(99, 0) < 70);
            x = rand_operand();
            y = rand_operand();
            drive_inputs(valid, x, y, "random");
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_prod_q.size() > 0 || n_results < n_strobes) && waited < drain_limit) begin
            idle_cycles(1);
            waited++;
        end
        if (n_results < n_strobes) begin
            other_errors++;
            $display("timeout: %0d of %0d results never arrived within %0d cycles",
                     n_strobes - n_results, n_strobes, drain_limit);
        end
    endtask

    initial begin
        int rand_state;
        rand_state = seed;
        void'($urandom(rand_state));
        rst = 1'b1;
        in_valid = 1'b0;
        a = '0;
        b = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
        check_en = 1'b1;

        phase = "after_reset";
        idle_cycles(8);

        phase = "corners";
        corner_operands();
        idle_cycles(3);

        phase = "back_to_back";
        burst_strobes();

        phase = "random";
        random_traffic();

        phase = "drain";
        wait_drain();
        idle_cycles(4);
        compare_value("result_count", row_t'(n_strobes), row_t'(n_results));

        $display("checks: %0d, value errors: %0d, other errors: %0d, strobes: %0d, results: %0d",
                 n_checks, value_errors, other_errors, n_strobes, n_results);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
logic/mul_pkg.sv
logic/partial_product_gen.sv
logic/csa_layer.sv
logic/cla_adder.sv
logic/pipe_stage.sv
logic/mul_top.sv
testbench/tb_clock.sv
testbench/mul_tb.sv

// File: Makefile
# Verilator build and run for the pipelined multiplier testbench
# Any variable below can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= mul_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_TEXT ?= CHECKS FAILED
PASS_TEXT ?= ALL CHECKS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
